/* filelist.f */
source/accel_pkg.sv
source/accel_ctrl.sv
source/coef_loader.sv
source/lane_mac.sv
source/result_writer.sv
source/vec_accel.sv
verification/tb_clock.sv
verification/tb_bus_mem.sv
verification/tb_vec_accel.sv

/* Makefile */
RTL = source/accel_pkg.sv source/accel_ctrl.sv source/coef_loader.sv \
      source/lane_mac.sv source/result_writer.sv source/vec_accel.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --assert $(RTL) --top-module vec_accel
	verilator --lint-only --timing --assert -f filelist.f --top-module tb_vec_accel

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_vec_accel \
		-o sim_vec_accel
	out=$$(./obj_dir/sim_vec_accel); echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* verification/tb_vec_accel.sv */
module tb_vec_accel;
   timeunit 1ns;
   timeprecision 1ps;
   import accel_pkg::*;

   localparam int n_lanes = n_lanes_def;
   localparam int lane_w  = lane_w_def;
   localparam int word_w  = n_lanes * lane_w;
   localparam int n_cases = 4;
   localparam int done_limit = 4000;

   typedef struct packed {
      logic [15:0] bias_addr;
      logic [15:0] bias;
      logic [15:0] weight;
      logic [15:0] len;
      logic [15:0] in_addr;
      logic [15:0] out_addr;
      logic [15:0] pat;
   } case_t;

   logic              clk;
   logic              rst;
   cpu_req_t          cpu_req;
   logic              ready;
   logic [31:0]       rdata;
   bus_req_t          rd0_req;
   bus_req_t          rd1_req;
   bus_req_t          wr_req;
   logic              rd0_ready;
   logic              rd1_ready;
   logic              wr_ready;
   logic [word_w-1:0] rd0_rdata;
   logic [word_w-1:0] rd1_rdata;
   logic [word_w-1:0] wr_wdata;
   logic [15:0]       win_lo;
   logic [15:0]       win_len;
   int                wr_count;
   int                bad_count;
   int                errors;
   int                timeouts;
   bit                ok;
   case_t             cases [n_cases];

   tb_clock #(.PERIOD(40), .RST_CYCLES(4)) i_clk (.clk(clk), .rst(rst));

   vec_accel #(.N_LANES(n_lanes), .LANE_W(lane_w)) i_dut (
      .clk(clk), .rst(rst), .cpu_req(cpu_req), .ready(ready), .rdata(rdata),
      .rd0_req(rd0_req), .rd0_ready(rd0_ready), .rd0_rdata(rd0_rdata),
      .rd1_req(rd1_req), .rd1_ready(rd1_ready), .rd1_rdata(rd1_rdata),
      .wr_req(wr_req), .wr_ready(wr_ready), .wr_wdata(wr_wdata)
   );

   tb_bus_mem #(.N_LANES(n_lanes), .LANE_W(lane_w), .SEED(32'hc546_614c)) i_mem (
      .clk(clk), .rst(rst),
      .rd0_req(rd0_req), .rd0_ready(rd0_ready), .rd0_rdata(rd0_rdata),
      .rd1_req(rd1_req), .rd1_ready(rd1_ready), .rd1_rdata(rd1_rdata),
      .wr_req(wr_req), .wr_ready(wr_ready), .wr_wdata(wr_wdata),
      .win_lo(win_lo), .win_len(win_len), .wr_count(wr_count), .bad_count(bad_count)
   );

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         errors++;
         $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   // lane values: bias + 3*l, weight - l, pat + 0x101*i + 0x11*l
   function automatic logic [word_w-1:0] bias_word(input case_t tc);
      logic [word_w-1:0] w;
      for (int l = 0; l < n_lanes; l++) w[l*lane_w +: lane_w] = tc.bias + lane_w'(3 * l);
      return w;
   endfunction

   function automatic logic [word_w-1:0] weight_word(input case_t tc);
      logic [word_w-1:0] w;
      for (int l = 0; l < n_lanes; l++) w[l*lane_w +: lane_w] = tc.weight - lane_w'(l);
      return w;
   endfunction

   function automatic logic [word_w-1:0] input_word(input case_t tc, input int i);
      logic [word_w-1:0] w;
      for (int l = 0; l < n_lanes; l++) begin
         w[l*lane_w +: lane_w] = tc.pat + lane_w'(16'h0101 * i) + lane_w'(16'h0011 * l);
      end
      return w;
   endfunction

   // bias + weight * input per lane, low 16 bits kept
   function automatic logic [word_w-1:0] expected_word(input case_t tc, input int i);
      logic [word_w-1:0] b;
      logic [word_w-1:0] w;
      logic [word_w-1:0] x;
      logic [word_w-1:0] e;
      logic [31:0]       p;
      b = bias_word(tc);
      w = weight_word(tc);
      x = input_word(tc, i);
      for (int l = 0; l < n_lanes; l++) begin
         p = 32'(w[l*lane_w +: lane_w]) * 32'(x[l*lane_w +: lane_w]);
         e[l*lane_w +: lane_w] = b[l*lane_w +: lane_w] + p[15:0];
      end
      return e;
   endfunction

   task automatic cpu_write(input logic [15:0] addr, input logic [31:0] data);
      int n;
      n = 0;
      @(posedge clk);
      #2;
      cpu_req = '{valid: 1'b1, addr: addr, wstrb: 1'b1, wdata: data};
      @(posedge clk);
      while (!ready && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (!ready) begin
         errors++;
         $display("cpu port never became ready for a write to %h", addr);
      end
      #2;
      cpu_req = '0;
   endtask

   task automatic wait_done(output bit done_ok);
      int n;
      n = 0;
      done_ok = 1'b0;
      while (!done_ok && n < done_limit) begin
         @(posedge clk);
         #2;
         done_ok = rdata[0];
         n++;
      end
      if (!done_ok) $display("timeout: done bit did not return to 1 after run");
   endtask

   // done must already be low one edge after the run write
   task automatic start_and_wait(output bit done_ok);
      cpu_write(reg_run_addr, 32'd0);
      @(posedge clk);
      #2;
      check("rdata after run", 64'd0, 64'(rdata));
      wait_done(done_ok);
   endtask

   task automatic run_case(input case_t tc, output bit done_ok);
      int base;
      i_mem.mem[tc.bias_addr]          = bias_word(tc);
      i_mem.mem[tc.bias_addr + 16'd1]  = weight_word(tc);
      for (int i = 0; i < int'(tc.len); i++) begin
         i_mem.mem[tc.in_addr + 16'(i)] = input_word(tc, i);
      end
      win_lo  = tc.out_addr;
      win_len = tc.len;
      cpu_write(reg_bias_addr, 32'(tc.bias_addr));
      cpu_write(reg_in_addr, 32'(tc.in_addr));
      cpu_write(reg_out_addr, 32'(tc.out_addr));
      cpu_write(reg_len, 32'(tc.len));
      base = wr_count;
      start_and_wait(done_ok);
      if (done_ok) begin
         check("wr_count", 64'(base + int'(tc.len)), 64'(wr_count));
         check("bad_count", 64'd0, 64'(bad_count));
         for (int i = 0; i < int'(tc.len); i++) begin
            check($sformatf("mem[%h]", tc.out_addr + 16'(i)), expected_word(tc, i),
                  i_mem.mem[tc.out_addr + 16'(i)]);
         end
      end
   endtask

   // clear leaves len at zero, so a run stores nothing
   task automatic run_clear_case(output bit done_ok);
      int base;
      win_lo  = 16'h0000;
      win_len = 16'h0000;
      cpu_write(reg_clear_addr, 32'd0);
      base = wr_count;
      start_and_wait(done_ok);
      if (done_ok) begin
         check("wr_count after clear", 64'(base), 64'(wr_count));
         check("bad_count", 64'd0, 64'(bad_count));
      end
   endtask

   initial begin
      int n;
      cpu_req  = '0;
      win_lo   = '0;
      win_len  = '0;
      errors   = 0;
      timeouts = 0;
      n        = 0;
      // single word with negative lanes, two longer runs, then overflow
      cases[0] = '{16'h0010, 16'hfff0, 16'hfffd, 16'd1, 16'h0020, 16'h0040, 16'h0007};
      cases[1] = '{16'h0012, 16'h0005, 16'h0003, 16'd8, 16'h0100, 16'h0200, 16'h0010};
      cases[2] = '{16'h0014, 16'h1234, 16'h0101, 16'd5, 16'h0300, 16'h0310, 16'h4321};
      cases[3] = '{16'h0016, 16'h7fff, 16'h0400, 16'd4, 16'h0400, 16'h0500, 16'h1234};
      while (rst && n < 20) begin
         @(posedge clk);
         n++;
      end
      ok = !rst;
      if (!ok) begin
         timeouts++;
         $display("timeout: reset was never released");
      end else begin
         #2;
         check("rdata after reset", 64'd1, 64'(rdata));
         repeat (3) begin
            @(posedge clk);
            #2;
            check("rd0_req.valid", 64'd0, 64'(rd0_req.valid));
            check("rd1_req.valid", 64'd0, 64'(rd1_req.valid));
            check("wr_req.valid", 64'd0, 64'(wr_req.valid));
         end
         for (int c = 0; c < n_cases && ok; c++) run_case(cases[c], ok);
         if (ok) run_clear_case(ok);
         if (!ok) timeouts++;
      end
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verification/tb_bus_mem.sv */
module tb_bus_mem #(
   parameter int          N_LANES = 4,
   parameter int          LANE_W  = 16,
   parameter logic [31:0] SEED    = 32'hc546_614c
) (
   input  logic                          clk,
   input  logic                          rst,
   input  accel_pkg::bus_req_t           rd0_req,
   output logic                          rd0_ready,
   output logic [N_LANES*LANE_W-1:0]     rd0_rdata,
   input  accel_pkg::bus_req_t           rd1_req,
   output logic                          rd1_ready,
   output logic [N_LANES*LANE_W-1:0]     rd1_rdata,
   input  accel_pkg::bus_req_t           wr_req,
   output logic                          wr_ready,
   input  logic [N_LANES*LANE_W-1:0]     wr_wdata,
   input  logic [accel_pkg::addr_w-1:0]  win_lo,
   input  logic [accel_pkg::addr_w-1:0]  win_len,
   output int                            wr_count,
   output int                            bad_count
);
   timeunit 1ns;
   timeprecision 1ps;
   import accel_pkg::*;

   logic [N_LANES*LANE_W-1:0] mem [0:(1 << addr_w) - 1];
   logic [addr_w-1:0]         wr_off;

   // every word starts with a value tied to its own address
   initial begin
      for (int a = 0; a < (1 << addr_w); a++) begin
         mem[a] = {N_LANES{addr_w'(a) ^ 16'ha5c3}};
      end
   end

   // readies change 1 ns after each edge, one seeded stream
   initial begin
      rd0_ready = 1'b0;
      rd1_ready = 1'b0;
      wr_ready  = 1'b0;
      void'($urandom(SEED));
      forever begin
         @(posedge clk);
         #1;
         rd0_ready = ($urandom % 4) != 0;
         rd1_ready = ($urandom % 3) != 0;
         wr_ready  = ($urandom % 2) != 0;
      end
   end

   assign rd0_rdata = mem[rd0_req.addr];
   assign rd1_rdata = mem[rd1_req.addr];
   assign wr_off    = wr_req.addr - win_lo;

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_count  <= 0;
         bad_count <= 0;
      end else begin
         if (wr_req.valid && wr_ready) begin
            mem[wr_req.addr] = wr_wdata;
            wr_count         <= wr_count + 1;
            if (wr_off >= win_len || !wr_req.write) bad_count <= bad_count + 1;
         end
         // read ports never ask for a write
         if ((rd0_req.valid && rd0_req.write) || (rd1_req.valid && rd1_req.write)) begin
            bad_count <= bad_count + 1;
         end
      end
   end

endmodule

/* verification/tb_clock.sv */
module tb_clock #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // release a little after the edge
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
   end

endmodule

/* source/vec_accel.sv */
module vec_accel #(
   parameter int N_LANES = accel_pkg::n_lanes_def,
   parameter int LANE_W  = accel_pkg::lane_w_def
) (
   input  logic                       clk,
   input  logic                       rst,
   // cpu port
   input  accel_pkg::cpu_req_t        cpu_req,
   output logic                       ready,
   output logic [31:0]                rdata,
   // coefficient reads
   output accel_pkg::bus_req_t        rd0_req,
   input  logic                       rd0_ready,
   input  logic [N_LANES*LANE_W-1:0]  rd0_rdata,
   // input word reads
   output accel_pkg::bus_req_t        rd1_req,
   input  logic                       rd1_ready,
   input  logic [N_LANES*LANE_W-1:0]  rd1_rdata,
   // result writes
   output accel_pkg::bus_req_t        wr_req,
   input  logic                       wr_ready,
   output logic [N_LANES*LANE_W-1:0]  wr_wdata
);
   import accel_pkg::*;

   unit_cfg_t                 cfg;
   logic                      run;
   logic                      clear;
   logic                      done_all;
   logic                      loader_done;
   logic                      mac_done;
   logic                      wr_idle;
   logic                      coef_ready;
   logic [N_LANES*LANE_W-1:0] bias;
   logic [N_LANES*LANE_W-1:0] weight;
   logic                      res_valid;
   logic [N_LANES*LANE_W-1:0] res_data;
   logic [addr_w-1:0]         res_addr;
   logic                      res_full;

   assign done_all = &{loader_done, mac_done, wr_idle};

   accel_ctrl u_ctrl (
      .clk(clk), .rst(rst), .cpu_req(cpu_req), .done_all(done_all),
      .ready(ready), .rdata(rdata), .cfg(cfg), .run(run), .clear(clear)
   );

   coef_loader #(.N_LANES(N_LANES), .LANE_W(LANE_W)) u_loader (
      .clk(clk), .rst(rst), .run(run), .clear(clear), .bias_addr(cfg.bias_addr),
      .bus_req(rd0_req), .bus_ready(rd0_ready), .bus_rdata(rd0_rdata),
      .bias(bias), .weight(weight), .coef_ready(coef_ready), .done(loader_done)
   );

   lane_mac #(.N_LANES(N_LANES), .LANE_W(LANE_W)) u_mac (
      .clk(clk), .rst(rst), .run(run), .clear(clear),
      .in_addr(cfg.in_addr), .out_addr(cfg.out_addr), .len(cfg.len),
      .coef_ready(coef_ready), .bias(bias), .weight(weight),
      .bus_req(rd1_req), .bus_ready(rd1_ready), .bus_rdata(rd1_rdata),
      .res_valid(res_valid), .res_data(res_data), .res_addr(res_addr),
      .res_full(res_full), .done(mac_done)
   );

   result_writer #(.N_LANES(N_LANES), .LANE_W(LANE_W)) u_writer (
      .clk(clk), .rst(rst), .clear(clear), .res_valid(res_valid),
      .res_data(res_data), .res_addr(res_addr), .res_full(res_full),
      .bus_req(wr_req), .bus_ready(wr_ready), .bus_wdata(wr_wdata), .idle(wr_idle)
   );

endmodule

/* source/result_writer.sv */
module result_writer #(
   parameter int N_LANES = 4,
   parameter int LANE_W  = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clear,
   input  logic                          res_valid,
   input  logic [N_LANES*LANE_W-1:0]     res_data,
   input  logic [accel_pkg::addr_w-1:0]  res_addr,
   output logic                          res_full,
   output accel_pkg::bus_req_t           bus_req,
   input  logic                          bus_ready,
   output logic [N_LANES*LANE_W-1:0]     bus_wdata,
   output logic                          idle
);
   import accel_pkg::*;

   logic                      full;
   logic                      accept;
   logic                      wr_fire;
   logic [addr_w-1:0]         addr_r;

   assign accept  = res_valid && !full;
   assign wr_fire = bus_req.valid && bus_ready;

   // full from the handoff until the write is taken
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         full <= 1'b0;
      end else if (clear) begin
         full <= 1'b0;
      end else if (accept) begin
         full <= 1'b1;
      end else if (wr_fire) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bus_wdata <= res_data;
         addr_r    <= res_addr;
      end
   end

   assign bus_req  = '{valid: full, addr: addr_r, write: 1'b1};
   assign res_full = full;
   assign idle     = !full;

   // a result offered while the buffer is full stays put until taken
   a_res_held: assert property (@(posedge clk) disable iff (rst)
      (res_valid && res_full && !clear) |=>
         (res_valid && $stable(res_data) && $stable(res_addr)))
      else $error("result changed while the write buffer was full");

endmodule

/* source/lane_mac.sv */
module lane_mac #(
   parameter int N_LANES = 4,
   parameter int LANE_W  = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   input  logic                          clear,
   input  logic [accel_pkg::addr_w-1:0]  in_addr,
   input  logic [accel_pkg::addr_w-1:0]  out_addr,
   input  logic [accel_pkg::addr_w-1:0]  len,
   input  logic                          coef_ready,
   input  logic [N_LANES*LANE_W-1:0]     bias,
   input  logic [N_LANES*LANE_W-1:0]     weight,
   output accel_pkg::bus_req_t           bus_req,
   input  logic                          bus_ready,
   input  logic [N_LANES*LANE_W-1:0]     bus_rdata,
   output logic                          res_valid,
   output logic [N_LANES*LANE_W-1:0]     res_data,
   output logic [accel_pkg::addr_w-1:0]  res_addr,
   input  logic                          res_full,
   output logic                          done
);
   import accel_pkg::*;

   mac_state_e                state;
   logic [addr_w-1:0]         cnt;
   logic                      rd_fire;
   logic [N_LANES*LANE_W-1:0] mac_word;

   assign rd_fire = bus_req.valid && bus_ready;

   // per lane bias + weight * input, wraps at LANE_W
   always_comb begin
      for (int i = 0; i < N_LANES; i++) begin
         mac_word[i*LANE_W +: LANE_W] = bias[i*LANE_W +: LANE_W]
            + weight[i*LANE_W +: LANE_W] * bus_rdata[i*LANE_W +: LANE_W];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= mac_idle;
         cnt   <= '0;
      end else if (clear) begin
         state <= mac_idle;
         cnt   <= '0;
      end else begin
         case (state)
            mac_idle, mac_done: begin
               if (run) begin
                  state <= mac_fetch;
                  cnt   <= '0;
               end
            end
            mac_fetch: begin
               if (cnt == len) begin
                  state <= mac_done;
               end else if (rd_fire) begin
                  state <= mac_hold;
               end
            end
            // wait here while the writer is busy
            mac_hold: begin
               if (!res_full) begin
                  state <= mac_fetch;
                  cnt   <= cnt + addr_w'(1);
               end
            end
            default: state <= mac_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         res_data <= mac_word;
         res_addr <= out_addr + cnt;
      end
   end

   // no fetch until the loader holds valid coefficients
   always_comb begin
      bus_req.valid = (state == mac_fetch) && coef_ready && (cnt != len);
      bus_req.addr  = in_addr + cnt;
      bus_req.write = 1'b0;
   end

   assign res_valid = (state == mac_hold);
   assign done      = (state == mac_idle) || (state == mac_done);

   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      (bus_req.valid && !bus_ready && !clear && !run) |=> $stable(bus_req))
      else $error("port 1 request changed before ready");

endmodule

/* source/coef_loader.sv */
module coef_loader #(
   parameter int N_LANES = 4,
   parameter int LANE_W  = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   input  logic                          clear,
   input  logic [accel_pkg::addr_w-1:0]  bias_addr,
   output accel_pkg::bus_req_t           bus_req,
   input  logic                          bus_ready,
   input  logic [N_LANES*LANE_W-1:0]     bus_rdata,
   output logic [N_LANES*LANE_W-1:0]     bias,
   output logic [N_LANES*LANE_W-1:0]     weight,
   output logic                          coef_ready,
   output logic                          done
);
   import accel_pkg::*;

   loader_state_e state;
   logic          rd_fire;

   assign rd_fire = bus_req.valid && bus_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= ld_idle;
      end else if (clear) begin
         state <= ld_idle;
      end else begin
         case (state)
            ld_idle, ld_done: begin
               if (run) state <= ld_bias;
            end
            ld_bias: begin
               if (rd_fire) state <= ld_weight;
            end
            ld_weight: begin
               if (rd_fire) state <= ld_done;
            end
            default: state <= ld_idle;
         endcase
      end
   end

   // captured words stay put until the next run
   always_ff @(posedge clk) begin
      if (rd_fire && state == ld_bias) bias <= bus_rdata;
      if (rd_fire && state == ld_weight) weight <= bus_rdata;
   end

   // weight word sits right after the bias word
   always_comb begin
      bus_req.valid = (state == ld_bias) || (state == ld_weight);
      bus_req.addr  = (state == ld_weight) ? bias_addr + addr_w'(1) : bias_addr;
      bus_req.write = 1'b0;
   end

   assign coef_ready = (state == ld_done);
   assign done       = (state == ld_idle) || (state == ld_done);

   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      (bus_req.valid && !bus_ready && !clear) |=> $stable(bus_req))
      else $error("port 0 request changed before ready");

endmodule

/* source/accel_ctrl.sv */
module accel_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  accel_pkg::cpu_req_t  cpu_req,
   input  logic                 done_all,
   output logic                 ready,
   output logic [31:0]          rdata,
   output accel_pkg::unit_cfg_t cfg,
   output logic                 run,
   output logic                 clear
);
   import accel_pkg::*;

   reg_op_e op;
   logic    run_r0;
   logic    run_r1;
   logic    clear_r0;
   logic    clear_r1;

   // only writes have an effect, reads return status
   always_comb begin
      op = op_none;
      if (cpu_req.valid && cpu_req.wstrb) begin
         if (!cpu_req.addr[ctrl_bit]) begin
            op = op_cfg;
         end else if (cpu_req.addr[clear_bit]) begin
            op = op_clear;
         end else begin
            op = op_run;
         end
      end
   end

   // config registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (op == op_clear) begin
         cfg <= '0;
      end else if (op == op_cfg) begin
         case (cpu_req.addr)
            reg_bias_addr: cfg.bias_addr <= cpu_req.wdata[addr_w-1:0];
            reg_in_addr:   cfg.in_addr   <= cpu_req.wdata[addr_w-1:0];
            reg_out_addr:  cfg.out_addr  <= cpu_req.wdata[addr_w-1:0];
            reg_len:       cfg.len       <= cpu_req.wdata[addr_w-1:0];
            default: ;
         endcase
      end
   end

   // registered decode, edge gives a single pulse even for a held write
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_r0   <= 1'b0;
         run_r1   <= 1'b0;
         clear_r0 <= 1'b0;
         clear_r1 <= 1'b0;
      end else begin
         run_r0   <= (op == op_run);
         run_r1   <= run_r0;
         clear_r0 <= (op == op_clear);
         clear_r1 <= clear_r0;
      end
   end

   assign run   = run_r0 & ~run_r1;
   assign clear = clear_r0 & ~clear_r1;

   // cpu sees only the done bit, port never stalls
   assign ready = 1'b1;
   assign rdata = {31'd0, done_all};

   a_run_single: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else $error("run pulse lasted more than one cycle");

endmodule

/* source/accel_pkg.sv */
package accel_pkg;

   // bus and register address width
   localparam int addr_w = 16;

   // defaults the top level turns into N_LANES and LANE_W
   localparam int n_lanes_def = 4;
   localparam int lane_w_def  = 16;

   // control region select and run/clear select inside it
   localparam int ctrl_bit  = 15;
   localparam int clear_bit = 14;

   // unit registers, bit 8 picks the unit
   localparam logic [addr_w-1:0] reg_bias_addr  = 16'h0000;
   localparam logic [addr_w-1:0] reg_in_addr    = 16'h0100;
   localparam logic [addr_w-1:0] reg_out_addr   = 16'h0101;
   localparam logic [addr_w-1:0] reg_len        = 16'h0102;
   localparam logic [addr_w-1:0] reg_run_addr   = 16'h8000;
   localparam logic [addr_w-1:0] reg_clear_addr = 16'hc000;

   typedef enum logic [1:0] {op_none, op_cfg, op_run, op_clear} reg_op_e;

   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
      logic              wstrb;
      logic [31:0]       wdata;
   } cpu_req_t;

   typedef struct packed {
      logic [addr_w-1:0] bias_addr;
      logic [addr_w-1:0] in_addr;
      logic [addr_w-1:0] out_addr;
      logic [addr_w-1:0] len;
   } unit_cfg_t;

   // data words travel beside this, their width is a parameter
   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
      logic              write;
   } bus_req_t;

   typedef enum logic [1:0] {ld_idle, ld_bias, ld_weight, ld_done} loader_state_e;
   typedef enum logic [1:0] {mac_idle, mac_fetch, mac_hold, mac_done} mac_state_e;

endpackage
